//--- cpuControlPkg.sv
package cpuControlPkg;

    // Major opcodes, bits 31:26 of the instruction
    typedef enum logic [5:0] {
        OpRType = 6'h00,
        OpJ     = 6'h02,
        OpBeq   = 6'h04,
        OpBne   = 6'h05,
        OpBle   = 6'h06,
        OpBgt   = 6'h07,
        OpAddi  = 6'h08,
        OpAddiu = 6'h09,
        OpSlti  = 6'h0a,
        OpLui   = 6'h0f,
        OpLb    = 6'h20,
        OpLh    = 6'h21,
        OpLw    = 6'h23
    } opcodeT;

    // R-type function codes, bits 5:0
    typedef enum logic [5:0] {
        FnJr    = 6'h08,
        FnBreak = 6'h0d,
        FnMfhi  = 6'h10,
        FnMflo  = 6'h12,
        FnRte   = 6'h13,
        FnMult  = 6'h18,
        FnDiv   = 6'h1a,
        FnAdd   = 6'h20,
        FnSub   = 6'h22,
        FnAnd   = 6'h24,
        FnSlt   = 6'h2a
    } functT;

    typedef enum logic [4:0] {
        ClassAdd, ClassAnd, ClassSub, ClassSlt,
        ClassDiv, ClassMult, ClassMfhi, ClassMflo,
        ClassJr, ClassBreak, ClassRte,
        ClassAddi, ClassAddiu, ClassSlti, ClassLui,
        ClassLw, ClassLb, ClassLh,
        ClassBeq, ClassBne, ClassBle, ClassBgt,
        ClassJ,
        ClassIllegal
    } instrClassT;

    typedef enum logic [2:0] {
        StReset,
        StFetch,
        StExec,
        StDivWait,
        StMultWait,
        StTrap
    } ctrlStateT;

    typedef logic [5:0] stepT;
    typedef logic [2:0] aluOpT;
    typedef logic [2:0] pcSrcT;
    typedef logic [3:0] memToRegT;
    typedef logic [2:0] regDstT;

    localparam aluOpT AluPass = 3'd0;
    localparam aluOpT AluAdd  = 3'd1;
    localparam aluOpT AluSub  = 3'd2;
    localparam aluOpT AluAnd  = 3'd3;
    localparam aluOpT AluCmp  = 3'd7;

    localparam pcSrcT PcSrcAlu    = 3'd0;
    localparam pcSrcT PcSrcBranch = 3'd1;
    localparam pcSrcT PcSrcJump   = 3'd2;
    localparam pcSrcT PcSrcEpc    = 3'd3;
    localparam pcSrcT PcSrcTrap   = 3'd4;

    // WbHi shares the load path encoding
    localparam memToRegT WbAlu = 4'd0;
    localparam memToRegT WbMem = 4'd3;
    localparam memToRegT WbHi  = 4'd3;
    localparam memToRegT WbLo  = 4'd4;
    localparam memToRegT WbLui = 4'd6;

    localparam regDstT DstRt = 3'd0;
    localparam regDstT DstRd = 3'd4;

    localparam logic [1:0] SrcBReg    = 2'd0;
    localparam logic [1:0] SrcBFour   = 2'd1;
    localparam logic [1:0] SrcBImm    = 2'd2;
    localparam logic [1:0] SrcBOffset = 2'd3;

    localparam logic [1:0] LsWord = 2'd0;
    localparam logic [1:0] LsByte = 2'd1;
    localparam logic [1:0] LsHalf = 2'd2;

    localparam logic [1:0] IorDData = 2'd2;

    // Phase lengths in cycles
    localparam stepT FetchSteps = 6'd5;
    localparam stepT ExecSteps  = 6'd2;
    localparam stepT DivSteps   = 6'd35;
    localparam stepT MultSteps  = 6'd34;
    localparam stepT SingleStep = 6'd1;

    typedef struct packed {
        pcSrcT      pcSrc;
        logic [1:0] iorD;
        regDstT     regDst;
        memToRegT   memToReg;
        logic       aluSrcA;
        logic [1:0] aluSrcB;
        aluOpT      aluOp;
        logic [1:0] lsControl;
        logic       hiSrc;
        logic       loSrc;
        logic       pcWrite;
        logic       memWr;
        logic       irWrite;
        logic       regWrite;
        logic       aWrite;
        logic       bWrite;
        logic       hiWrite;
        logic       loWrite;
        logic       aluOutWrite;
        logic       epcWrite;
        logic       divControl;
        logic       multControl;
    } ctrlWordT;

    localparam ctrlWordT CtrlIdle = '0;

endpackage

//--- instrDecoder.sv
module instrDecoder (
    input  cpuControlPkg::opcodeT     OpCode,
    input  cpuControlPkg::functT      Funct,
    output cpuControlPkg::instrClassT InstrClass
);
    import cpuControlPkg::*;

    instrClassT rClass;

    // R-type class from the function field
    always_comb begin
        case (Funct)
            FnAdd:   rClass = ClassAdd;
            FnAnd:   rClass = ClassAnd;
            FnSub:   rClass = ClassSub;
            FnSlt:   rClass = ClassSlt;
            FnDiv:   rClass = ClassDiv;
            FnMult:  rClass = ClassMult;
            FnMfhi:  rClass = ClassMfhi;
            FnMflo:  rClass = ClassMflo;
            FnJr:    rClass = ClassJr;
            FnBreak: rClass = ClassBreak;
            FnRte:   rClass = ClassRte;
            default: rClass = ClassIllegal;
        endcase
    end

    always_comb begin
        case (OpCode)
            OpRType: InstrClass = rClass;
            OpAddi:  InstrClass = ClassAddi;
            OpAddiu: InstrClass = ClassAddiu;
            OpSlti:  InstrClass = ClassSlti;
            OpLui:   InstrClass = ClassLui;
            OpLw:    InstrClass = ClassLw;
            OpLb:    InstrClass = ClassLb;
            OpLh:    InstrClass = ClassLh;
            OpBeq:   InstrClass = ClassBeq;
            OpBne:   InstrClass = ClassBne;
            OpBle:   InstrClass = ClassBle;
            OpBgt:   InstrClass = ClassBgt;
            OpJ:     InstrClass = ClassJ;
            default: InstrClass = ClassIllegal;
        endcase
    end

endmodule

//--- controlSequencer.sv
module controlSequencer (
    input  logic                      Clock,
    input  logic                      arstN,
    input  cpuControlPkg::instrClassT InstrClass,
    input  logic                      ExceptionSignal,
    output cpuControlPkg::ctrlStateT  State,
    output cpuControlPkg::stepT       Step,
    output logic                      ResetSignal,
    output logic                      AllowException,
    output logic                      OpcodeError
);
    import cpuControlPkg::*;

    ctrlStateT stateNext;
    stepT      stepNext;
    stepT      stepLimit;
    logic      lastStep;
    logic      overflowTrap;
    logic      illegalTrap;

    // Number of cycles spent in each phase
    always_comb begin
        case (State)
            StFetch:    stepLimit = FetchSteps;
            StExec:     stepLimit = ExecSteps;
            StDivWait:  stepLimit = DivSteps;
            StMultWait: stepLimit = MultSteps;
            default:    stepLimit = SingleStep;
        endcase
    end

    assign lastStep = (Step == stepLimit - 1'b1);

    assign ResetSignal = (State == StReset);

    // Only the signed adds and sub may raise overflow
    assign AllowException = (State == StExec) &&
                            (InstrClass == ClassAdd ||
                             InstrClass == ClassSub ||
                             InstrClass == ClassAddi);

    // Overflow is taken before the write-back step
    assign overflowTrap = AllowException && ExceptionSignal && (Step == '0);

    assign illegalTrap = (State == StFetch) && lastStep && (InstrClass == ClassIllegal);

    always_comb begin
        stateNext = State;
        stepNext  = Step + 1'b1;
        if (lastStep) begin
            stepNext = '0;
            case (State)
                StFetch: begin
                    case (InstrClass)
                        ClassIllegal: stateNext = StTrap;
                        ClassDiv:     stateNext = StDivWait;
                        ClassMult:    stateNext = StMultWait;
                        default:      stateNext = StExec;
                    endcase
                end
                StReset, StExec, StDivWait, StMultWait, StTrap: begin
                    stateNext = StFetch;
                end
                default: begin
                    stateNext = StReset;
                end
            endcase
        end
        if (overflowTrap) begin
            stateNext = StTrap;
            stepNext  = '0;
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            State       <= StReset;
            Step        <= '0;
            OpcodeError <= 1'b0;
        end else begin
            State       <= stateNext;
            Step        <= stepNext;
            // Flag shows during the trap cycle that follows decode
            OpcodeError <= illegalTrap;
        end
    end

    assert property (@(posedge Clock) disable iff (!arstN) Step < stepLimit)
        else $error("step counter outside the current phase");

    assert property (@(posedge Clock) disable iff (!arstN) OpcodeError |-> State == StTrap)
        else $error("opcode error outside the trap phase");

    // Trap is a single cycle, fetch resumes right after
    assert property (@(posedge Clock) disable iff (!arstN)
                     State == StTrap |=> State == StFetch && Step == '0)
        else $error("trap phase did not return to fetch");

endmodule

//--- controlWordGen.sv
module controlWordGen (
    input  cpuControlPkg::ctrlStateT  State,
    input  cpuControlPkg::stepT       Step,
    input  cpuControlPkg::instrClassT InstrClass,
    input  logic                      Gt,
    input  logic                      Eq,
    output cpuControlPkg::ctrlWordT   Ctrl
);
    import cpuControlPkg::*;

    logic       firstStep;
    logic       taken;
    aluOpT      arithOp;
    logic [1:0] loadSize;

    assign firstStep = (Step == '0);

    // Branch decision from the compare flags
    always_comb begin
        case (InstrClass)
            ClassBeq: taken = Eq;
            ClassBne: taken = !Eq;
            ClassBle: taken = !Gt;
            ClassBgt: taken = Gt;
            default:  taken = 1'b0;
        endcase
    end

    always_comb begin
        case (InstrClass)
            ClassAdd, ClassAddi, ClassAddiu: arithOp = AluAdd;
            ClassAnd:                        arithOp = AluAnd;
            ClassSub:                        arithOp = AluSub;
            ClassSlt, ClassSlti:             arithOp = AluCmp;
            default:                         arithOp = AluPass;
        endcase
        case (InstrClass)
            ClassLb: loadSize = LsByte;
            ClassLh: loadSize = LsHalf;
            default: loadSize = LsWord;
        endcase
    end

    always_comb begin
        Ctrl = CtrlIdle;
        case (State)
            StFetch: begin
                // PC + 4 computed through steps 0 to 2
                if (Step < 6'd3) begin
                    Ctrl.aluSrcB = SrcBFour;
                    Ctrl.aluOp   = AluAdd;
                end
                Ctrl.pcWrite = (Step == 6'd2);
                Ctrl.irWrite = (Step == 6'd2);
                Ctrl.aWrite  = (Step == 6'd3);
                Ctrl.bWrite  = (Step == 6'd3);
            end
            StExec: begin
                case (InstrClass)
                    ClassAdd, ClassAnd, ClassSub, ClassSlt,
                    ClassAddi, ClassAddiu, ClassSlti: begin
                        Ctrl.aluSrcA     = 1'b1;
                        Ctrl.aluOp       = arithOp;
                        Ctrl.memToReg    = WbAlu;
                        Ctrl.aluOutWrite = firstStep;
                        Ctrl.regWrite    = !firstStep;
                        if (InstrClass == ClassAddi || InstrClass == ClassAddiu ||
                            InstrClass == ClassSlti) begin
                            Ctrl.aluSrcB = SrcBImm;
                            Ctrl.regDst  = DstRt;
                        end else begin
                            Ctrl.aluSrcB = SrcBReg;
                            Ctrl.regDst  = DstRd;
                        end
                    end
                    ClassLui: begin
                        Ctrl.regDst   = DstRt;
                        Ctrl.memToReg = WbLui;
                        Ctrl.regWrite = !firstStep;
                    end
                    ClassMfhi, ClassMflo: begin
                        Ctrl.regDst   = DstRd;
                        Ctrl.memToReg = (InstrClass == ClassMfhi) ? WbHi : WbLo;
                        Ctrl.regWrite = !firstStep;
                    end
                    ClassLw, ClassLb, ClassLh: begin
                        Ctrl.aluSrcA   = 1'b1;
                        Ctrl.aluSrcB   = SrcBOffset;
                        Ctrl.aluOp     = AluAdd;
                        Ctrl.iorD      = IorDData;
                        Ctrl.lsControl = loadSize;
                        Ctrl.memToReg  = WbMem;
                        Ctrl.regDst    = DstRt;
                        Ctrl.regWrite  = !firstStep;
                    end
                    ClassJr: begin
                        Ctrl.aluSrcA = 1'b1;
                        Ctrl.aluOp   = AluPass;
                        Ctrl.pcSrc   = PcSrcAlu;
                        Ctrl.pcWrite = firstStep;
                    end
                    ClassBreak: begin
                        // Step the PC back onto the break itself
                        Ctrl.aluSrcB = SrcBFour;
                        Ctrl.aluOp   = AluSub;
                        Ctrl.pcSrc   = PcSrcAlu;
                        Ctrl.pcWrite = firstStep;
                    end
                    ClassRte: begin
                        Ctrl.pcSrc    = PcSrcEpc;
                        Ctrl.epcWrite = firstStep;
                    end
                    ClassJ: begin
                        Ctrl.pcSrc   = PcSrcJump;
                        Ctrl.pcWrite = firstStep;
                    end
                    ClassBeq, ClassBne, ClassBle, ClassBgt: begin
                        if (firstStep) begin
                            Ctrl.aluSrcA = 1'b1;
                            Ctrl.aluSrcB = SrcBReg;
                            Ctrl.aluOp   = AluCmp;
                            Ctrl.pcSrc   = PcSrcBranch;
                            Ctrl.pcWrite = taken;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            StDivWait: begin
                if (Step < DivSteps - 1'b1) begin
                    Ctrl.divControl = 1'b1;
                end else begin
                    Ctrl.hiSrc   = 1'b1;
                    Ctrl.loSrc   = 1'b1;
                    Ctrl.hiWrite = 1'b1;
                    Ctrl.loWrite = 1'b1;
                end
            end
            StMultWait: begin
                if (Step < MultSteps - 1'b1) begin
                    Ctrl.multControl = 1'b1;
                end else begin
                    Ctrl.hiWrite = 1'b1;
                    Ctrl.loWrite = 1'b1;
                end
            end
            StTrap: begin
                Ctrl.pcSrc    = PcSrcTrap;
                Ctrl.pcWrite  = 1'b1;
                Ctrl.epcWrite = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- controlUnit.sv
module controlUnit (
    input  logic                    Clock,
    input  logic                    arstN,
    input  logic                    Gt,
    input  logic                    Lt,
    input  logic                    Eq,
    input  logic                    Zero,
    input  cpuControlPkg::opcodeT   OpCode,
    input  cpuControlPkg::functT    Funct,
    input  logic                    ExceptionSignal,
    output cpuControlPkg::ctrlWordT Ctrl,
    output logic                    ResetSignal,
    output logic                    AllowException,
    output logic                    OpcodeError
);
    import cpuControlPkg::*;

    instrClassT InstrClass;
    ctrlStateT  State;
    stepT       Step;

    instrDecoder i_instrDecoder (
        .OpCode     (OpCode),
        .Funct      (Funct),
        .InstrClass (InstrClass)
    );

    controlSequencer i_controlSequencer (
        .Clock           (Clock),
        .arstN           (arstN),
        .InstrClass      (InstrClass),
        .ExceptionSignal (ExceptionSignal),
        .State           (State),
        .Step            (Step),
        .ResetSignal     (ResetSignal),
        .AllowException  (AllowException),
        .OpcodeError     (OpcodeError)
    );

    // Lt and Zero go to the datapath, no kept instruction needs them
    controlWordGen i_controlWordGen (
        .State      (State),
        .Step       (Step),
        .InstrClass (InstrClass),
        .Gt         (Gt),
        .Eq         (Eq),
        .Ctrl       (Ctrl)
    );

endmodule

//--- tbControlModel.svh
`ifndef TB_CONTROL_MODEL_SVH
`define TB_CONTROL_MODEL_SVH

// Cycles spent in each phase
function automatic logic [5:0] phaseLength(input ctrlStateT phase);
    case (phase)
        StFetch:    return 6'd5;
        StExec:     return 6'd2;
        StDivWait:  return 6'd35;
        StMultWait: return 6'd34;
        default:    return 6'd1;
    endcase
endfunction

// Phase entered after the decode step
function automatic ctrlStateT nextAfterDecode(input instrClassT cls);
    case (cls)
        ClassIllegal: return StTrap;
        ClassDiv:     return StDivWait;
        ClassMult:    return StMultWait;
        default:      return StExec;
    endcase
endfunction

function automatic logic trapsOnOverflow(input instrClassT cls);
    return cls == ClassAdd || cls == ClassSub || cls == ClassAddi;
endfunction

function automatic logic branchTaken(input instrClassT cls, input logic gt, input logic eq);
    case (cls)
        ClassBeq: return eq;
        ClassBne: return !eq;
        ClassBle: return !gt;
        ClassBgt: return gt;
        default:  return 1'b0;
    endcase
endfunction

// Whole instruction in cycles, fetch included
function automatic int expectedLength(input instrClassT cls, input logic overflow);
    case (cls)
        ClassIllegal: return 5 + 1;
        ClassDiv:     return 5 + 35;
        ClassMult:    return 5 + 34;
        default:      return (overflow && trapsOnOverflow(cls)) ? 5 + 1 + 1 : 5 + 2;
    endcase
endfunction

function automatic ctrlWordT execWord(input logic [5:0] step, input instrClassT cls,
                                      input logic gt, input logic eq);
    ctrlWordT w;
    logic     first;
    logic     immForm;
    w = '0;
    first = (step == 6'd0);
    immForm = cls inside {ClassAddi, ClassAddiu, ClassSlti};
    case (cls)
        ClassAdd, ClassAnd, ClassSub, ClassSlt, ClassAddi, ClassAddiu, ClassSlti: begin
            w.aluSrcA = 1'b1;
            w.aluSrcB = immForm ? SrcBImm : 2'd0;
            w.regDst = immForm ? DstRt : DstRd;
            w.aluOp = (cls == ClassAnd) ? AluAnd :
                      (cls == ClassSub) ? AluSub :
                      (cls == ClassSlt || cls == ClassSlti) ? AluCmp : AluAdd;
            w.aluOutWrite = first;
            w.regWrite = !first;
        end
        ClassLw, ClassLb, ClassLh: begin
            w.aluSrcA = 1'b1;
            w.aluSrcB = SrcBOffset;
            w.aluOp = AluAdd;
            w.iorD = 2'd2;
            w.lsControl = (cls == ClassLb) ? LsByte : (cls == ClassLh) ? LsHalf : LsWord;
            w.memToReg = WbMem;
            w.regDst = DstRt;
            w.regWrite = !first;
        end
        ClassLui: begin
            w.memToReg = WbLui;
            w.regDst = DstRt;
            w.regWrite = !first;
        end
        ClassMfhi, ClassMflo: begin
            w.memToReg = (cls == ClassMfhi) ? WbHi : WbLo;
            w.regDst = DstRd;
            w.regWrite = !first;
        end
        ClassJr: begin
            w.aluSrcA = 1'b1;
            w.pcWrite = first;
        end
        ClassBreak: begin
            // PC minus four, back onto the break
            w.aluSrcB = SrcBFour;
            w.aluOp = AluSub;
            w.pcWrite = first;
        end
        ClassRte: begin
            w.pcSrc = PcSrcEpc;
            w.epcWrite = first;
        end
        ClassJ: begin
            w.pcSrc = PcSrcJump;
            w.pcWrite = first;
        end
        ClassBeq, ClassBne, ClassBle, ClassBgt: begin
            if (first) begin
                w.aluSrcA = 1'b1;
                w.aluOp = AluCmp;
                w.pcSrc = PcSrcBranch;
                w.pcWrite = branchTaken(cls, gt, eq);
            end
        end
        default: begin
        end
    endcase
    return w;
endfunction

function automatic ctrlWordT expectedWord(input ctrlStateT phase, input logic [5:0] step,
                                          input instrClassT cls, input logic gt,
                                          input logic eq);
    ctrlWordT w;
    w = '0;
    case (phase)
        StFetch: begin
            // PC + 4 held on the ALU up to the PC write
            if (step <= 6'd2) begin
                w.aluSrcB = SrcBFour;
                w.aluOp = AluAdd;
            end
            w.pcWrite = (step == 6'd2);
            w.irWrite = (step == 6'd2);
            w.aWrite = (step == 6'd3);
            w.bWrite = (step == 6'd3);
        end
        StExec: begin
            w = execWord(step, cls, gt, eq);
        end
        StDivWait: begin
            w.divControl = (step < 6'd34);
            w.hiWrite = (step == 6'd34);
            w.loWrite = (step == 6'd34);
            w.hiSrc = (step == 6'd34);
            w.loSrc = (step == 6'd34);
        end
        StMultWait: begin
            w.multControl = (step < 6'd33);
            w.hiWrite = (step == 6'd33);
            w.loWrite = (step == 6'd33);
        end
        StTrap: begin
            w.pcSrc = PcSrcTrap;
            w.pcWrite = 1'b1;
            w.epcWrite = 1'b1;
        end
        default: begin
        end
    endcase
    return w;
endfunction

`endif

//--- tbControlUnit.sv
module tbControlUnit;
    import cpuControlPkg::*;

    typedef struct packed {
        opcodeT     op;
        functT      fn;
        instrClassT cls;
    } instrEntryT;

    `include "tbControlModel.svh"

    localparam int TableSize = 25;
    localparam int RandomCount = 60;

    // Last two entries are sw and sll, both illegal here
    localparam instrEntryT InstrTable [TableSize] = '{
        '{OpRType, FnAdd, ClassAdd}, '{OpRType, FnAnd, ClassAnd},
        '{OpRType, FnSub, ClassSub}, '{OpRType, FnSlt, ClassSlt},
        '{OpRType, FnDiv, ClassDiv}, '{OpRType, FnMult, ClassMult},
        '{OpRType, FnMfhi, ClassMfhi}, '{OpRType, FnMflo, ClassMflo},
        '{OpRType, FnJr, ClassJr}, '{OpRType, FnBreak, ClassBreak},
        '{OpRType, FnRte, ClassRte}, '{OpAddi, FnAdd, ClassAddi},
        '{OpAddiu, FnAdd, ClassAddiu}, '{OpSlti, FnAdd, ClassSlti},
        '{OpLui, FnAdd, ClassLui}, '{OpLw, FnAdd, ClassLw},
        '{OpLb, FnAdd, ClassLb}, '{OpLh, FnAdd, ClassLh},
        '{OpBeq, FnAdd, ClassBeq}, '{OpBne, FnAdd, ClassBne},
        '{OpBle, FnAdd, ClassBle}, '{OpBgt, FnAdd, ClassBgt},
        '{OpJ, FnAdd, ClassJ},
        '{opcodeT'(6'h2b), FnAdd, ClassIllegal},
        '{OpRType, functT'(6'h00), ClassIllegal}
    };

    logic       Clock;
    logic       arstN;
    logic       Gt;
    logic       Lt;
    logic       Eq;
    logic       Zero;
    opcodeT     OpCode;
    functT      Funct;
    logic       ExceptionSignal;
    ctrlWordT   Ctrl;
    logic       ResetSignal;
    logic       AllowException;
    logic       OpcodeError;

    ctrlStateT   expPhase = StReset;
    logic [5:0]  expStep = '0;
    instrClassT  curClass;
    logic        curExc;
    int          checkCount = 0;
    int          errorCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 100;
    logic [31:0] rngState = 32'd8;
    instrEntryT  seqInstr[$];
    logic [3:0]  seqFlags[$];

    controlUnit i_controlUnit (
        .Clock           (Clock),
        .arstN           (arstN),
        .Gt              (Gt),
        .Lt              (Lt),
        .Eq              (Eq),
        .Zero            (Zero),
        .OpCode          (OpCode),
        .Funct           (Funct),
        .ExceptionSignal (ExceptionSignal),
        .Ctrl            (Ctrl),
        .ResetSignal     (ResetSignal),
        .AllowException  (AllowException),
        .OpcodeError     (OpcodeError)
    );

    always #4 Clock = ~Clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH at %0t: %s in %s step %0d, expected %h, got %h",
                     $time, what, expPhase.name(), expStep, expected, actual);
        end
    endtask

    // Flags are {exception, gt, eq, lt}, with one compare outcome per instruction
    task automatic addInstr(input instrEntryT entry, input logic exc);
        logic [1:0] cmp;
        rngState = xorshift(rngState);
        cmp = 2'(rngState % 32'd3);
        seqInstr.push_back(entry);
        seqFlags.push_back({exc, cmp == 2'd2, cmp == 2'd1, cmp == 2'd0});
        cycleLimit = cycleLimit + expectedLength(entry.cls, exc);
    endtask

    task automatic driveInstr(input instrEntryT entry, input logic [3:0] flags);
        OpCode = entry.op;
        Funct = entry.fn;
        ExceptionSignal = flags[3];
        Gt = flags[2];
        Eq = flags[1];
        Lt = flags[0];
        Zero = flags[1];
        curClass = entry.cls;
        curExc = flags[3];
    endtask

    // Expected phase and step, then the outputs in the middle of the high phase
    always @(posedge Clock) begin
        if (!arstN) begin
            expPhase = StReset;
            expStep = '0;
        end else if (expPhase == StExec && expStep == 6'd0 && trapsOnOverflow(curClass) &&
                     curExc) begin
            expPhase = StTrap;
            expStep = '0;
        end else if (expStep != phaseLength(expPhase) - 6'd1) begin
            expStep = expStep + 6'd1;
        end else begin
            expStep = '0;
            expPhase = (expPhase == StFetch) ? nextAfterDecode(curClass) : StFetch;
        end
        #2;
        checkValue(64'(Ctrl), 64'(expectedWord(expPhase, expStep, curClass, Gt, Eq)), "Ctrl");
        checkValue(64'(ResetSignal), 64'(expPhase == StReset), "ResetSignal");
        checkValue(64'(AllowException), 64'(expPhase == StExec && trapsOnOverflow(curClass)),
                   "AllowException");
        checkValue(64'(OpcodeError), 64'(expPhase == StTrap && curClass == ClassIllegal),
                   "OpcodeError");
    end

    always @(posedge Clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        int         idx;
        instrEntryT entry;
        logic [3:0] flags;
        Clock = 1'b0;
        arstN = 1'b0;
        driveInstr(InstrTable[0], 4'b0000);
        // Every entry once, then the overflow cases, then random picks
        for (idx = 0; idx < TableSize; idx++) begin
            addInstr(InstrTable[idx], 1'b0);
        end
        addInstr(InstrTable[0], 1'b1);
        addInstr(InstrTable[2], 1'b1);
        addInstr(InstrTable[11], 1'b1);
        addInstr(InstrTable[12], 1'b1);
        repeat (RandomCount) begin
            rngState = xorshift(rngState);
            idx = int'(rngState % 32'(TableSize));
            addInstr(InstrTable[idx], rngState[12:11] == 2'b00);
        end
        repeat (16) @(negedge Clock);
        arstN = 1'b1;
        #2;
        checkValue(64'(ResetSignal), 64'd1, "ResetSignal after reset release");
        checkValue(64'(Ctrl), 64'd0, "Ctrl after reset release");
        @(negedge Clock);
        // Each instruction is applied during its own fetch step 0
        while (seqInstr.size() > 0) begin
            entry = seqInstr.pop_front();
            flags = seqFlags.pop_front();
            driveInstr(entry, flags);
            repeat (expectedLength(entry.cls, flags[3])) @(negedge Clock);
        end
        $display("Checks: %0d, mismatches: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
cpuControlPkg.sv
instrDecoder.sv
controlSequencer.sv
controlWordGen.sv
controlUnit.sv
tbControlUnit.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module tbControlUnit -o simControlUnit
./obj_dir/simControlUnit > sim.log
cat sim.log
if grep -q ">>> FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
